//--- vlog.f
verilog/lc3b_pkg.sv
verilog/regfile.sv
verilog/alu.sv
verilog/decode.sv
verilog/execute.sv
verilog/writeback.sv
verilog/lc3b_exec_top.sv
bench/tb_lc3b_exec.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary -f vlog.f --top-module tb_lc3b_exec -Mdir obj_dir -o sim
	./obj_dir/sim > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "No errors" sim.log || (echo "test failed, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- bench/tb_lc3b_exec.sv
module tb_lc3b_exec;

localparam int reset_cycles = 16;
localparam int alu_ops = 32;
localparam int chain_len = 12;
localparam int addr_ops = 16;
// each test drains for two cycles and each branch holds off for one.
localparam int max_cycles = reset_cycles + 8 + 3 * (8 + alu_ops) + 3 * chain_len + 4
                            + addr_ops + 3 + 3 * (1 + 2 * 8) + 7 + 50;

typedef struct packed {
    logic valid;
    logic writes;
    logic [15:0] result;
    logic [2:0] dr;
    logic [2:0] cc;
    logic rd;
    logic wr;
    logic [15:0] addr;
    logic branch;
    logic taken;
    logic [15:0] target;
} expect_t;

logic clk;
logic rst_n;
logic instr_valid;
logic [15:0] instr;
logic [15:0] npc;

logic issue_stall;
logic wb_valid;
logic [15:0] wb_result;
logic [2:0] wb_dr;
logic [2:0] wb_cc;
logic mem_read;
logic mem_write;
logic [15:0] mem_address;
logic branch_taken;
logic [15:0] branch_target;

// reference model state.
logic [15:0] regs [0:7];
logic [2:0] cc;
logic [15:0] pc;
logic [31:0] lfsr;
expect_t in_ex;
expect_t in_wb;
string test_name;
int cycles = 0;

lc3b_exec_top DUT
(
    .clk(clk), .rst_n(rst_n),
    .instr_valid(instr_valid), .instr(instr), .npc(npc),
    .issue_stall(issue_stall), .wb_valid(wb_valid), .wb_result(wb_result),
    .wb_dr(wb_dr), .wb_cc(wb_cc), .mem_read(mem_read), .mem_write(mem_write),
    .mem_address(mem_address), .branch_taken(branch_taken),
    .branch_target(branch_target)
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > max_cycles) begin
        $display("Errors found");
        $fatal(1, "the run went past %0d cycles without finishing", max_cycles);
    end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// helpers.
function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    logic out_bit;
    v = '0;
    for (int i = 0; i < n; i++) begin
        out_bit = lfsr[0];
        lfsr = lfsr >> 1;
        if (out_bit)
            lfsr = lfsr ^ 32'h80200003;
        v = {v[14:0], out_bit};
    end
    return v;
endfunction

function automatic logic [15:0] sext(input logic [15:0] v, input int bits);
    return 16'($signed(v << (16 - bits)) >>> (16 - bits));
endfunction

function automatic logic [2:0] cc_of(input logic [15:0] val);
    return val[15] ? 3'b100 : (val == 16'h0000 ? 3'b010 : 3'b001);
endfunction

task check_value(input string field, input logic [15:0] expected,
                 input logic [15:0] actual);
    if (expected !== actual) begin
        $display("Fail %s %s expected %h actual %h", test_name, field, expected, actual);
        $display("Errors found");
        $fatal(1, "output mismatch");
    end
endtask

task compare_outputs;
    check_value("wb_valid", 16'(in_wb.valid), 16'(wb_valid));
    check_value("mem_read", 16'(in_wb.rd), 16'(mem_read));
    check_value("mem_write", 16'(in_wb.wr), 16'(mem_write));
    check_value("branch_taken", 16'(in_wb.taken), 16'(branch_taken));
    check_value("issue_stall", 16'(in_ex.branch), 16'(issue_stall));
    if (in_wb.valid) begin
        check_value("wb_cc", 16'(in_wb.cc), 16'(wb_cc));
        if (in_wb.writes) begin
            check_value("wb_dr", 16'(in_wb.dr), 16'(wb_dr));
            check_value("wb_result", in_wb.result, wb_result);
        end
        if (in_wb.rd || in_wb.wr)
            check_value("mem_address", in_wb.addr, mem_address);
        if (in_wb.branch)
            check_value("branch_target", in_wb.target, branch_target);
    end
endtask

// checks what the last edge produced and drives the next slot.
task advance(input expect_t e, input logic v, input logic [15:0] ins);
    @(negedge clk);
    compare_outputs();
    in_wb = in_ex;
    in_ex = e;
    instr_valid = v;
    instr = ins;
    npc = pc;
endtask

task idle;
    advance('0, 1'b0, 16'h0000);
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// isa model applied in program order at issue.
task issue(input logic [15:0] ins);
    expect_t e;
    logic [2:0] dr;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] r;
    logic set_cc;
    e = '0;
    e.valid = 1'b1;
    set_cc = 1'b0;
    r = '0;
    dr = ins[11:9];
    a = regs[ins[8:6]];
    b = ins[5] ? sext(ins, 5) : regs[ins[2:0]];
    pc = pc + 16'd2;
    case (ins[15:12])
        4'b0001: begin
            r = a + b;
            e.writes = 1'b1;
            set_cc = 1'b1;
        end
        4'b0101: begin
            r = a & b;
            e.writes = 1'b1;
            set_cc = 1'b1;
        end
        4'b1001: begin
            r = ~a;
            e.writes = 1'b1;
            set_cc = 1'b1;
        end
        4'b1101: begin
            if (!ins[4])
                r = a << ins[3:0];
            else if (!ins[5])
                r = a >> ins[3:0];
            else
                r = 16'($signed(a) >>> ins[3:0]);
            e.writes = 1'b1;
            set_cc = 1'b1;
        end
        4'b1110: begin
            r = pc + (sext(ins, 9) << 1);
            e.writes = 1'b1;
        end
        4'b0110, 4'b0111: begin
            e.rd = !ins[12];
            e.wr = ins[12];
            e.addr = a + (sext(ins, 6) << 1);
        end
        4'b0010, 4'b0011: begin
            e.rd = !ins[12];
            e.wr = ins[12];
            e.addr = a + sext(ins, 6);
        end
        4'b0000: begin
            e.branch = 1'b1;
            e.taken = |(ins[11:9] & cc);
            e.target = pc + (sext(ins, 9) << 1);
        end
        4'b1100: begin
            e.branch = 1'b1;
            e.taken = 1'b1;
            e.target = a;
        end
        default: begin
            $display("Errors found");
            $fatal(1, "testbench tried to issue an unsupported opcode");
        end
    endcase
    if (e.writes) begin
        regs[dr] = r;
        e.result = r;
        e.dr = dr;
    end
    if (set_cc)
        cc = cc_of(r);
    e.cc = cc;
    advance(e, 1'b1, ins);
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests.
task reset_state;
    test_name = "reset_state";
    idle();
    idle();
    // cc is z out of reset.
    issue({4'b0000, 3'b010, 9'(rand_bits(9))});
    idle();
    issue({4'b0000, 3'b101, 9'(rand_bits(9))});
    idle();
    idle();
    idle();
endtask

task alu_ops_test;
    logic [1:0] op;
    logic [1:0] kind;
    logic [2:0] dr;
    logic [2:0] sr1;
    logic [5:0] low;
    test_name = "alu_ops";
    for (int i = 0; i < 8; i++) begin
        issue({4'b0001, 3'(i), 3'(i), 1'b1, 5'(rand_bits(5))});
        idle();
        idle();
    end
    for (int i = 0; i < alu_ops; i++) begin
        op = 2'(rand_bits(2));
        dr = 3'(rand_bits(3));
        sr1 = 3'(rand_bits(3));
        if (rand_bits(1))
            low = {1'b1, 5'(rand_bits(5))};
        else
            low = {3'b000, 3'(rand_bits(3))};
        kind = 2'(rand_bits(2));
        // 10 is not a shift kind.
        if (kind == 2'b10)
            kind = 2'b11;
        case (op)
            2'd0: issue({4'b0001, dr, sr1, low});
            2'd1: issue({4'b0101, dr, sr1, low});
            2'd2: issue({4'b1001, dr, sr1, 6'b111111});
            default: issue({4'b1101, dr, sr1, kind, 4'(rand_bits(4))});
        endcase
        idle();
        idle();
    end
endtask

task forwarding_chain(input int gap);
    logic [2:0] dr;
    logic [2:0] prev1;
    logic [2:0] prev2;
    prev1 = 3'(rand_bits(3));
    prev2 = 3'(rand_bits(3));
    for (int i = 0; i < chain_len; i++) begin
        dr = 3'(rand_bits(3));
        if (rand_bits(1))
            issue({4'b0001, dr, prev1, 3'b000, prev2});
        else
            issue({4'b0101, dr, prev1, 3'b000, prev2});
        repeat (gap) idle();
        prev2 = prev1;
        prev1 = dr;
    end
    idle();
    idle();
endtask

task back_to_back_forwarding;
    test_name = "back_to_back_forwarding";
    forwarding_chain(0);
    forwarding_chain(1);
endtask

task address_gen;
    logic [2:0] kind;
    logic [2:0] dr;
    logic [2:0] base;
    logic [5:0] off6;
    test_name = "address_gen";
    // lea results near the pc are positive, and an lea that loaded cc would leave z.
    issue({4'b0101, 3'd0, 3'd0, 1'b1, 5'd0});
    for (int i = 0; i < addr_ops; i++) begin
        kind = 3'(rand_bits(3));
        dr = 3'(rand_bits(3));
        base = 3'(rand_bits(3));
        off6 = 6'(rand_bits(6));
        case (kind)
            3'd0, 3'd5: issue({4'b1110, dr, 9'(rand_bits(9))});
            3'd1, 3'd6: issue({4'b0110, dr, base, off6});
            3'd2, 3'd7: issue({4'b0111, dr, base, off6});
            3'd3: issue({4'b0010, dr, base, off6});
            default: issue({4'b0011, dr, base, off6});
        endcase
    end
    idle();
    idle();
endtask

task branch_masks;
    for (int m = 0; m < 8; m++) begin
        issue({4'b0000, 3'(m), 9'(rand_bits(9))});
        idle();
    end
endtask

task branches;
    test_name = "branches";
    // cc goes z then n then p.
    issue({4'b0101, 3'd1, 3'd1, 1'b1, 5'd0});
    branch_masks();
    issue({4'b0001, 3'd2, 3'd1, 1'b1, 5'b11100});
    branch_masks();
    issue({4'b0001, 3'd3, 3'd1, 1'b1, 5'd5});
    branch_masks();
    issue({4'b1100, 3'b000, 3'd2, 6'b000000});
    idle();
    // base comes from the instruction still in execute.
    issue({4'b0001, 3'd4, 3'd3, 1'b1, 5'(rand_bits(5))});
    issue({4'b1100, 3'b000, 3'd4, 6'b000000});
    idle();
    idle();
    idle();
endtask

initial begin
    rst_n = 1'b0;
    instr_valid = 1'b0;
    instr = '0;
    npc = '0;
    pc = 16'h3000;
    lfsr = 32'h592b358c;
    cc = 3'b010;
    in_ex = '0;
    in_wb = '0;
    test_name = "reset";
    for (int i = 0; i < 8; i++) begin
        regs[i] = '0;
    end
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    reset_state();
    alu_ops_test();
    back_to_back_forwarding();
    address_gen();
    branches();

    $display("No errors");
    $finish;
end

endmodule : tb_lc3b_exec

//--- verilog/lc3b_exec_top.sv
module lc3b_exec_top
(
    input  logic clk,
    input  logic rst_n,

    input  logic instr_valid,
    input  logic [lc3b_pkg::word_w-1:0] instr,
    input  logic [lc3b_pkg::word_w-1:0] npc,

    output logic issue_stall,
    output logic wb_valid,
    output logic [lc3b_pkg::word_w-1:0] wb_result,
    output logic [lc3b_pkg::reg_w-1:0] wb_dr,
    output logic [lc3b_pkg::cc_w-1:0] wb_cc,
    output logic mem_read,
    output logic mem_write,
    output logic [lc3b_pkg::word_w-1:0] mem_address,
    output logic branch_taken,
    output logic [lc3b_pkg::word_w-1:0] branch_target
);

logic [lc3b_pkg::reg_w-1:0] sr1_addr;
logic [lc3b_pkg::reg_w-1:0] sr2_addr;
logic [lc3b_pkg::word_w-1:0] sr1_data;
logic [lc3b_pkg::word_w-1:0] sr2_data;

logic id_valid;
logic [lc3b_pkg::word_w-1:0] id_ir;
logic [lc3b_pkg::word_w-1:0] id_npc;
logic [lc3b_pkg::word_w-1:0] id_sr1;
logic [lc3b_pkg::word_w-1:0] id_sr2;
logic [lc3b_pkg::reg_w-1:0] id_dr;
lc3b_pkg::lc3b_aluop aluop;
lc3b_pkg::addr1_sel addr1mux_sel;
lc3b_pkg::addr2_sel addr2mux_sel;
logic lshf_enable;
logic sr2mux_sel;
logic memaddrmux_sel;
logic load_cc;
logic load_regfile;
logic id_mem_read;
logic id_mem_write;
logic mem_byte;
logic branch_stall;

logic [lc3b_pkg::word_w-1:0] ex_result;
logic [lc3b_pkg::word_w-1:0] address;
logic [lc3b_pkg::reg_w-1:0] ex_dr;
logic ex_load_cc;
logic ex_load_regfile;
logic ex_mem_read;
logic ex_mem_write;

logic wb_we;

decode decode
(
    .clk(clk), .rst_n(rst_n),
    .instr_valid(instr_valid), .instr(instr), .npc(npc),
    .sr1_addr(sr1_addr), .sr2_addr(sr2_addr),
    .sr1_data(sr1_data), .sr2_data(sr2_data),
    .ex_result(ex_result), .ex_dr(ex_dr), .ex_load_regfile(ex_load_regfile),
    .id_valid(id_valid), .id_ir(id_ir), .id_npc(id_npc),
    .id_sr1(id_sr1), .id_sr2(id_sr2), .id_dr(id_dr),
    .aluop(aluop), .addr1mux_sel(addr1mux_sel), .addr2mux_sel(addr2mux_sel),
    .lshf_enable(lshf_enable), .sr2mux_sel(sr2mux_sel),
    .memaddrmux_sel(memaddrmux_sel), .load_cc(load_cc),
    .load_regfile(load_regfile), .mem_read(id_mem_read),
    .mem_write(id_mem_write), .mem_byte(mem_byte), .branch_stall(branch_stall)
);

regfile regfile
(
    .clk(clk), .rst_n(rst_n),
    .sr1_addr(sr1_addr), .sr2_addr(sr2_addr),
    .sr1_data(sr1_data), .sr2_data(sr2_data),
    .we(wb_we), .dr(wb_dr), .wdata(wb_result)
);

execute execute
(
    .id_valid(id_valid), .id_ir(id_ir), .id_npc(id_npc),
    .id_sr1(id_sr1), .id_sr2(id_sr2), .id_dr(id_dr),
    .aluop(aluop), .addr1mux_sel(addr1mux_sel), .addr2mux_sel(addr2mux_sel),
    .lshf_enable(lshf_enable), .sr2mux_sel(sr2mux_sel),
    .memaddrmux_sel(memaddrmux_sel), .load_cc(load_cc),
    .load_regfile(load_regfile), .mem_read(id_mem_read),
    .mem_write(id_mem_write), .mem_byte(mem_byte), .branch_stall(branch_stall),
    .ex_result(ex_result), .address(address), .ex_dr(ex_dr),
    .ex_load_cc(ex_load_cc), .ex_load_regfile(ex_load_regfile),
    .ex_branch_stall(issue_stall),
    .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write)
);

writeback writeback
(
    .clk(clk), .rst_n(rst_n),
    .id_valid(id_valid), .id_ir(id_ir),
    .ex_result(ex_result), .address(address), .ex_dr(ex_dr),
    .ex_load_cc(ex_load_cc), .ex_load_regfile(ex_load_regfile),
    .ex_branch_stall(issue_stall),
    .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
    .wb_we(wb_we), .wb_dr(wb_dr), .wb_result(wb_result),
    .wb_valid(wb_valid), .wb_cc(wb_cc),
    .mem_read(mem_read), .mem_write(mem_write), .mem_address(mem_address),
    .branch_taken(branch_taken), .branch_target(branch_target)
);

endmodule : lc3b_exec_top

//--- verilog/writeback.sv
module writeback
(
    input  logic clk,
    input  logic rst_n,

    input  logic id_valid,
    input  logic [lc3b_pkg::word_w-1:0] id_ir,
    input  logic [lc3b_pkg::word_w-1:0] ex_result,
    input  logic [lc3b_pkg::word_w-1:0] address,
    input  logic [lc3b_pkg::reg_w-1:0] ex_dr,
    input  logic ex_load_cc,
    input  logic ex_load_regfile,
    input  logic ex_branch_stall,
    input  logic ex_mem_read,
    input  logic ex_mem_write,

    output logic wb_we,
    output logic [lc3b_pkg::reg_w-1:0] wb_dr,
    output logic [lc3b_pkg::word_w-1:0] wb_result,
    output logic wb_valid,
    output logic [lc3b_pkg::cc_w-1:0] wb_cc,
    output logic mem_read,
    output logic mem_write,
    output logic [lc3b_pkg::word_w-1:0] mem_address,
    output logic branch_taken,
    output logic [lc3b_pkg::word_w-1:0] branch_target
);

logic wb_load_cc;
logic wb_branch;
logic is_jmp;
logic [lc3b_pkg::word_w-1:0] wb_ir;
logic [lc3b_pkg::cc_w-1:0] nzp;
logic [lc3b_pkg::cc_w-1:0] cc_reg;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ex/wb latch.
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        wb_valid <= 1'b0;
        wb_we <= 1'b0;
        wb_load_cc <= 1'b0;
        wb_branch <= 1'b0;
        mem_read <= 1'b0;
        mem_write <= 1'b0;
    end else begin
        wb_valid <= id_valid;
        wb_we <= ex_load_regfile;
        wb_load_cc <= ex_load_cc;
        wb_branch <= ex_branch_stall;
        mem_read <= ex_mem_read;
        mem_write <= ex_mem_write;
    end
end

always_ff @(posedge clk) begin
    wb_result <= ex_result;
    wb_dr <= ex_dr;
    wb_ir <= id_ir;
    mem_address <= address;
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// condition codes.
assign nzp[2] = wb_result[lc3b_pkg::word_w-1];
assign nzp[1] = wb_result == '0;
assign nzp[0] = !nzp[2] && !nzp[1];

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        cc_reg <= lc3b_pkg::cc_zero;
    end else if (wb_load_cc) begin
        cc_reg <= nzp;
    end
end

// cc as it stands after this instruction.
assign wb_cc = wb_load_cc ? nzp : cc_reg;

// branch tests the cc left by all older instructions.
assign is_jmp = lc3b_pkg::lc3b_opcode'(wb_ir[lc3b_pkg::opcode_msb:lc3b_pkg::opcode_lsb])
                == lc3b_pkg::op_jmp;
assign branch_taken = wb_branch
                      && (is_jmp || |(wb_ir[lc3b_pkg::nzp_msb:lc3b_pkg::nzp_lsb] & cc_reg));
assign branch_target = mem_address;

endmodule : writeback

//--- verilog/execute.sv
module execute
(
    input  logic id_valid,
    input  logic [lc3b_pkg::word_w-1:0] id_ir,
    input  logic [lc3b_pkg::word_w-1:0] id_npc,
    input  logic [lc3b_pkg::word_w-1:0] id_sr1,
    input  logic [lc3b_pkg::word_w-1:0] id_sr2,
    input  logic [lc3b_pkg::reg_w-1:0] id_dr,

    input  lc3b_pkg::lc3b_aluop aluop,
    input  lc3b_pkg::addr1_sel addr1mux_sel,
    input  lc3b_pkg::addr2_sel addr2mux_sel,
    input  logic lshf_enable,
    input  logic sr2mux_sel,
    input  logic memaddrmux_sel,
    input  logic load_cc,
    input  logic load_regfile,
    input  logic mem_read,
    input  logic mem_write,
    input  logic mem_byte,
    input  logic branch_stall,

    output logic [lc3b_pkg::word_w-1:0] ex_result,
    output logic [lc3b_pkg::word_w-1:0] address,
    output logic [lc3b_pkg::reg_w-1:0] ex_dr,
    output logic ex_load_cc,
    output logic ex_load_regfile,
    output logic ex_branch_stall,
    output logic ex_mem_read,
    output logic ex_mem_write
);

localparam int w = lc3b_pkg::word_w;

logic [w-1:0] base;
logic [w-1:0] offset;
logic [w-1:0] scaled;
logic [w-1:0] sum;
logic [w-1:0] trap_addr;
logic [w-1:0] alu_a;
logic [w-1:0] alu_b;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address path.
assign base = (addr1mux_sel == lc3b_pkg::addr1_sr1) ? id_sr1 : id_npc;

always_comb begin
    case (addr2mux_sel)
        lc3b_pkg::addr2_off6:
            offset = {{(w-6){id_ir[5]}}, id_ir[5:0]};
        lc3b_pkg::addr2_off9:
            offset = {{(w-9){id_ir[8]}}, id_ir[8:0]};
        lc3b_pkg::addr2_off11:
            offset = {{(w-11){id_ir[10]}}, id_ir[10:0]};
        default:
            offset = '0;
    endcase
end

// byte accesses never scale the offset.
assign scaled = (lshf_enable && !mem_byte) ? {offset[w-2:0], 1'b0} : offset;
assign sum = base + scaled;

// trap vector, zero extended and doubled.
assign trap_addr = {{(w-9){1'b0}}, id_ir[7:0], 1'b0};
assign address = memaddrmux_sel ? sum : trap_addr;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lea routes the effective address through the alu.
assign alu_a = (aluop == lc3b_pkg::alu_pass) ? address : id_sr1;
assign alu_b = sr2mux_sel ? {{(w-5){id_ir[4]}}, id_ir[4:0]} : id_sr2;

alu alu
(
    .aluop(aluop),
    .a(alu_a),
    .b(alu_b),
    .f(ex_result)
);

assign ex_dr = id_dr;

// nothing leaves execute unless the slot holds an instruction.
assign ex_load_cc = id_valid & load_cc;
assign ex_load_regfile = id_valid & load_regfile;
assign ex_branch_stall = id_valid & branch_stall;
assign ex_mem_read = id_valid & mem_read;
assign ex_mem_write = id_valid & mem_write;

endmodule : execute

//--- verilog/decode.sv
module decode
(
    input  logic clk,
    input  logic rst_n,

    input  logic instr_valid,
    input  logic [lc3b_pkg::word_w-1:0] instr,
    input  logic [lc3b_pkg::word_w-1:0] npc,

    output logic [lc3b_pkg::reg_w-1:0] sr1_addr,
    output logic [lc3b_pkg::reg_w-1:0] sr2_addr,
    input  logic [lc3b_pkg::word_w-1:0] sr1_data,
    input  logic [lc3b_pkg::word_w-1:0] sr2_data,

    input  logic [lc3b_pkg::word_w-1:0] ex_result,
    input  logic [lc3b_pkg::reg_w-1:0] ex_dr,
    input  logic ex_load_regfile,

    output logic id_valid,
    output logic [lc3b_pkg::word_w-1:0] id_ir,
    output logic [lc3b_pkg::word_w-1:0] id_npc,
    output logic [lc3b_pkg::word_w-1:0] id_sr1,
    output logic [lc3b_pkg::word_w-1:0] id_sr2,
    output logic [lc3b_pkg::reg_w-1:0] id_dr,

    output lc3b_pkg::lc3b_aluop aluop,
    output lc3b_pkg::addr1_sel addr1mux_sel,
    output lc3b_pkg::addr2_sel addr2mux_sel,
    output logic lshf_enable,
    output logic sr2mux_sel,
    output logic memaddrmux_sel,
    output logic load_cc,
    output logic load_regfile,
    output logic mem_read,
    output logic mem_write,
    output logic mem_byte,
    output logic branch_stall
);

lc3b_pkg::lc3b_opcode opcode;
lc3b_pkg::lc3b_aluop d_aluop;
lc3b_pkg::addr2_sel d_addr2;
logic is_alu;
logic is_store;
logic [lc3b_pkg::word_w-1:0] op1;
logic [lc3b_pkg::word_w-1:0] op2;

assign opcode = lc3b_pkg::lc3b_opcode'(instr[lc3b_pkg::opcode_msb:lc3b_pkg::opcode_lsb]);

assign is_alu = opcode inside {lc3b_pkg::op_add, lc3b_pkg::op_and,
                               lc3b_pkg::op_not, lc3b_pkg::op_shf};
assign is_store = opcode inside {lc3b_pkg::op_str, lc3b_pkg::op_stb};

// stores read their source through the second port.
assign sr1_addr = instr[lc3b_pkg::sr1_msb:lc3b_pkg::sr1_lsb];
assign sr2_addr = is_store ? instr[lc3b_pkg::dr_msb:lc3b_pkg::dr_lsb]
                           : instr[lc3b_pkg::sr2_msb:lc3b_pkg::sr2_lsb];

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control word.
always_comb begin
    case (opcode)
        lc3b_pkg::op_add:
            d_aluop = lc3b_pkg::alu_add;
        lc3b_pkg::op_and:
            d_aluop = lc3b_pkg::alu_and;
        lc3b_pkg::op_not:
            d_aluop = lc3b_pkg::alu_not;
        lc3b_pkg::op_shf:
            if (!instr[4])
                d_aluop = lc3b_pkg::alu_sll;
            else if (instr[5])
                d_aluop = lc3b_pkg::alu_sra;
            else
                d_aluop = lc3b_pkg::alu_srl;
        default:
            d_aluop = lc3b_pkg::alu_pass;
    endcase

    case (opcode)
        lc3b_pkg::op_lea, lc3b_pkg::op_br:
            d_addr2 = lc3b_pkg::addr2_off9;
        lc3b_pkg::op_ldr, lc3b_pkg::op_str, lc3b_pkg::op_ldb, lc3b_pkg::op_stb:
            d_addr2 = lc3b_pkg::addr2_off6;
        default:
            d_addr2 = lc3b_pkg::addr2_zero;
    endcase
end

// newest value wins, the one still in execute.
assign op1 = (ex_load_regfile && ex_dr == sr1_addr) ? ex_result : sr1_data;
assign op2 = (ex_load_regfile && ex_dr == sr2_addr) ? ex_result : sr2_data;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// id/ex latch.
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        id_valid <= 1'b0;
        load_cc <= 1'b0;
        load_regfile <= 1'b0;
        mem_read <= 1'b0;
        mem_write <= 1'b0;
        branch_stall <= 1'b0;
    end else begin
        id_valid <= instr_valid;
        load_cc <= is_alu;
        load_regfile <= is_alu || opcode == lc3b_pkg::op_lea;
        mem_read <= opcode inside {lc3b_pkg::op_ldr, lc3b_pkg::op_ldb};
        mem_write <= is_store;
        branch_stall <= opcode inside {lc3b_pkg::op_br, lc3b_pkg::op_jmp};
    end
end

always_ff @(posedge clk) begin
    id_ir <= instr;
    id_npc <= npc;
    id_sr1 <= op1;
    id_sr2 <= op2;
    id_dr <= instr[lc3b_pkg::dr_msb:lc3b_pkg::dr_lsb];
    aluop <= d_aluop;
    addr1mux_sel <= (opcode inside {lc3b_pkg::op_lea, lc3b_pkg::op_br})
                    ? lc3b_pkg::addr1_npc : lc3b_pkg::addr1_sr1;
    addr2mux_sel <= d_addr2;
    lshf_enable <= opcode inside {lc3b_pkg::op_lea, lc3b_pkg::op_br,
                                  lc3b_pkg::op_ldr, lc3b_pkg::op_str};
    sr2mux_sel <= opcode == lc3b_pkg::op_shf
                  || (opcode inside {lc3b_pkg::op_add, lc3b_pkg::op_and}
                      && instr[lc3b_pkg::imm_flag_bit]);
    // unused codes fall back to the trap vector address.
    memaddrmux_sel <= opcode inside {lc3b_pkg::op_lea, lc3b_pkg::op_br,
                                     lc3b_pkg::op_jmp, lc3b_pkg::op_ldr,
                                     lc3b_pkg::op_str, lc3b_pkg::op_ldb,
                                     lc3b_pkg::op_stb};
    mem_byte <= opcode inside {lc3b_pkg::op_ldb, lc3b_pkg::op_stb};
end

endmodule : decode

//--- verilog/alu.sv
module alu
(
    input  lc3b_pkg::lc3b_aluop aluop,
    input  logic [lc3b_pkg::word_w-1:0] a,
    input  logic [lc3b_pkg::word_w-1:0] b,
    output logic [lc3b_pkg::word_w-1:0] f
);

logic [3:0] shamt;

// shifts take the low four bits only.
assign shamt = b[3:0];

always_comb begin
    case (aluop)
        lc3b_pkg::alu_add:
            f = a + b;
        lc3b_pkg::alu_and:
            f = a & b;
        lc3b_pkg::alu_not:
            f = ~a;
        lc3b_pkg::alu_sll:
            f = a << shamt;
        lc3b_pkg::alu_srl:
            f = a >> shamt;
        lc3b_pkg::alu_sra:
            f = $signed(a) >>> shamt;
        default:
            f = a;
    endcase
end

endmodule : alu

//--- verilog/regfile.sv
module regfile
(
    input  logic clk,
    input  logic rst_n,

    input  logic [lc3b_pkg::reg_w-1:0] sr1_addr,
    input  logic [lc3b_pkg::reg_w-1:0] sr2_addr,
    output logic [lc3b_pkg::word_w-1:0] sr1_data,
    output logic [lc3b_pkg::word_w-1:0] sr2_data,

    input  logic we,
    input  logic [lc3b_pkg::reg_w-1:0] dr,
    input  logic [lc3b_pkg::word_w-1:0] wdata
);

localparam int num_regs = 1 << lc3b_pkg::reg_w;

logic [lc3b_pkg::word_w-1:0] regs [0:num_regs-1];

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
        end
    end else if (we) begin
        regs[dr] <= wdata;
    end
end

// write-through, so decode sees a value being written this cycle.
assign sr1_data = (we && dr == sr1_addr) ? wdata : regs[sr1_addr];
assign sr2_data = (we && dr == sr2_addr) ? wdata : regs[sr2_addr];

endmodule : regfile

//--- verilog/lc3b_pkg.sv
package lc3b_pkg;

localparam int word_w = 16;
localparam int reg_w = 3;
localparam int cc_w = 3;

// cc value out of reset.
localparam logic [cc_w-1:0] cc_zero = 3'b010;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction fields.
localparam int opcode_msb = 15;
localparam int opcode_lsb = 12;
localparam int dr_msb = 11;
localparam int dr_lsb = 9;
localparam int sr1_msb = 8;
localparam int sr1_lsb = 6;
localparam int sr2_msb = 2;
localparam int sr2_lsb = 0;
localparam int imm_flag_bit = 5;
// same bits as dr, read by branches.
localparam int nzp_msb = 11;
localparam int nzp_lsb = 9;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// codes not named here are not handled by this slice.
typedef enum logic [3:0] {
    op_br  = 4'b0000,
    op_add = 4'b0001,
    op_ldb = 4'b0010,
    op_stb = 4'b0011,
    op_and = 4'b0101,
    op_ldr = 4'b0110,
    op_str = 4'b0111,
    op_not = 4'b1001,
    op_jmp = 4'b1100,
    op_shf = 4'b1101,
    op_lea = 4'b1110
} lc3b_opcode;

typedef enum logic [2:0] {
    alu_add,
    alu_and,
    alu_not,
    alu_pass,
    alu_sll,
    alu_srl,
    alu_sra
} lc3b_aluop;

typedef enum logic {
    addr1_npc,
    addr1_sr1
} addr1_sel;

typedef enum logic [1:0] {
    addr2_zero,
    addr2_off6,
    addr2_off9,
    addr2_off11
} addr2_sel;

endpackage : lc3b_pkg
